/* hdl/backend_pkg.sv */
package backend_pkg;

    // datapath sizes
    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int byte_lanes  = xlen / 8;

    // data memory geometry, word index from address bits 11:2
    localparam int mem_depth   = 1024;
    localparam int mem_index_w = 10;

    // memory opcodes carried from execute
    typedef enum logic [2:0] {
        mem_none = 3'd0,
        mem_lw   = 3'd1,
        mem_lb   = 3'd2,
        mem_lbu  = 3'd3,
        mem_sw   = 3'd4,
        mem_sb   = 3'd5
    } mem_op_e;

    // execute to memory bundle
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       alu_result;  // address for loads and stores
        logic [xlen-1:0]       write_data;  // store data
        logic [reg_addr_w-1:0] rd;
        mem_op_e               mem_op;
        logic                  reg_write;
        logic                  mem_to_reg;
    } ex_mem_t;

    // memory to writeback bundle
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       read_data;   // formatted load data, zero otherwise
        logic [xlen-1:0]       alu_result;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic                  mem_to_reg;
    } mem_wb_t;

    // register file write, also a forwarding source
    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } reg_write_t;

endpackage

/* hdl/data_memory.sv */
`timescale 1ns/1ps

module data_memory
    import backend_pkg::*;
(
    input  logic                   clk,
    input  logic [mem_index_w-1:0] index,
    input  logic [xlen-1:0]        wdata,
    input  logic [byte_lanes-1:0]  byte_en,
    input  logic                   we,
    output logic [xlen-1:0]        rdata
);

    logic [xlen-1:0] mem [mem_depth];

    // start from a known all-zero image
    initial begin
        for (int i = 0; i < mem_depth; i++) begin
            mem[i] = '0;
        end
    end

    // per-byte write at the rising edge
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < byte_lanes; b++) begin
                if (byte_en[b]) begin
                    mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // combinational read, shows contents before the edge
    assign rdata = mem[index];

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage
    import backend_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   hazard_stall,
    input  logic                   hazard_flush,
    input  ex_mem_t                ex_mem,
    output logic [mem_index_w-1:0] mem_index,
    output logic [xlen-1:0]        mem_wdata,
    output logic [byte_lanes-1:0]  mem_byte_en,
    output logic                   mem_we,
    input  logic [xlen-1:0]        mem_rdata,
    output mem_wb_t                mem_wb
);

    logic            take;       // bundle accepted this edge
    logic            is_store;
    logic [1:0]      lane;
    logic [7:0]      sel_byte;
    logic [xlen-1:0] load_data;
    mem_wb_t         wb_next;

    assign take      = ex_mem.valid && !hazard_stall && !hazard_flush;
    assign lane      = ex_mem.alu_result[1:0];
    assign mem_index = ex_mem.alu_result[mem_index_w+1:2]; // upper bits ignored, wraps

    // store decode
    always_comb begin
        is_store    = 1'b0;
        mem_byte_en = '0;
        mem_wdata   = ex_mem.write_data;
        case (ex_mem.mem_op)
            mem_sw: begin
                is_store    = 1'b1;
                mem_byte_en = '1;
            end
            mem_sb: begin
                is_store    = 1'b1;
                mem_byte_en = byte_lanes'(1) << lane;
                mem_wdata   = {byte_lanes{ex_mem.write_data[7:0]}}; // low byte on every lane
            end
            default: ;
        endcase
    end

    assign mem_we = take && is_store;

    // load formatting
    assign sel_byte = mem_rdata[lane*8 +: 8];

    always_comb begin
        case (ex_mem.mem_op)
            mem_lw:  load_data = mem_rdata;
            mem_lb:  load_data = {{(xlen-8){sel_byte[7]}}, sel_byte};
            mem_lbu: load_data = {{(xlen-8){1'b0}}, sel_byte};
            default: load_data = '0;   // non-loads carry zero
        endcase
    end

    always_comb begin
        wb_next            = '0;
        wb_next.valid      = 1'b1;
        wb_next.pc         = ex_mem.pc;
        wb_next.read_data  = load_data;
        wb_next.alu_result = ex_mem.alu_result;
        wb_next.rd         = ex_mem.rd;
        wb_next.reg_write  = ex_mem.reg_write;
        wb_next.mem_to_reg = ex_mem.mem_to_reg;
    end

    // memory/writeback register
    // flush beats stall, stall beats valid
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_wb <= '0;
        end else if (hazard_flush) begin
            mem_wb <= '0;
        end else if (hazard_stall) begin
            mem_wb.valid <= 1'b0;   // hold contents, drop strobe
        end else if (ex_mem.valid) begin
            mem_wb <= wb_next;
        end else begin
            mem_wb.valid <= 1'b0;
        end
    end

endmodule

/* hdl/writeback_regfile.sv */
`timescale 1ns/1ps

module writeback_regfile
    import backend_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  mem_wb_t               mem_wb,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data,
    output reg_write_t            reg_write
);

    localparam int num_regs = 2 ** reg_addr_w;

    // x0 has no storage
    logic [xlen-1:0] regs [1:num_regs-1];

    // writeback source select
    always_comb begin
        reg_write.en   = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);
        reg_write.rd   = mem_wb.rd;
        reg_write.data = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write.en) begin
            regs[reg_write.rd] <= reg_write.data;   // rd is never zero here
        end
    end

    // write-first read with x0 forced to zero
    function automatic logic [xlen-1:0] read_port(
        input logic [reg_addr_w-1:0] addr
    );
        logic [xlen-1:0] value;
        if (reg_write.en && (reg_write.rd == addr)) begin
            value = reg_write.data;   // same-cycle bypass
        end else if (addr == '0) begin
            value = '0;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

/* hdl/mem_wb_backend.sv */
`timescale 1ns/1ps

module mem_wb_backend
    import backend_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  hazard_stall,
    input  logic                  hazard_flush,
    input  ex_mem_t               ex_mem,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    output mem_wb_t               mem_wb,
    output reg_write_t            reg_write,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data
);

    // memory request and response
    logic [mem_index_w-1:0] mem_index;
    logic [xlen-1:0]        mem_wdata;
    logic [byte_lanes-1:0]  mem_byte_en;
    logic                   mem_we;
    logic [xlen-1:0]        mem_rdata;

    mem_stage u_mem_stage (
        .clk          (clk),
        .reset_n      (reset_n),
        .hazard_stall (hazard_stall),
        .hazard_flush (hazard_flush),
        .ex_mem       (ex_mem),
        .mem_index    (mem_index),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_we       (mem_we),
        .mem_rdata    (mem_rdata),
        .mem_wb       (mem_wb)
    );

    data_memory u_data_memory (
        .clk     (clk),
        .index   (mem_index),
        .wdata   (mem_wdata),
        .byte_en (mem_byte_en),
        .we      (mem_we),
        .rdata   (mem_rdata)
    );

    writeback_regfile u_writeback (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_wb    (mem_wb),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .reg_write (reg_write)
    );

endmodule

/* sim/mem_wb_assertions.sv */
`timescale 1ns/1ps

module mem_wb_assertions
    import backend_pkg::*;
(
    input logic    clk,
    input logic    reset_n,
    input logic    hazard_stall,
    input logic    hazard_flush,
    input ex_mem_t ex_mem,
    input logic    mem_we,
    input mem_wb_t mem_wb
);

    int   fail_count = 0;
    logic take;

    assign take = ex_mem.valid && !hazard_stall && !hazard_flush;

    // no write without a bundle, so quiet after reset
    we_needs_valid: assert property (@(posedge clk) disable iff (!reset_n)
        mem_we |-> ex_mem.valid)
        else begin
            $error("memory write without a valid bundle");
            fail_count++;
        end

    we_blocked: assert property (@(posedge clk) disable iff (!reset_n)
        mem_we |-> !hazard_stall && !hazard_flush)
        else begin
            $error("memory write during stall or flush");
            fail_count++;
        end

    valid_follows: assert property (@(posedge clk) disable iff (!reset_n)
        take |=> mem_wb.valid)
        else begin
            $error("mem_wb.valid missing after an accepted bundle");
            fail_count++;
        end

    valid_only_on_take: assert property (@(posedge clk) disable iff (!reset_n)
        !take |=> !mem_wb.valid)
        else begin
            $error("mem_wb.valid high without an accepted bundle");
            fail_count++;
        end

    flush_clears: assert property (@(posedge clk) disable iff (!reset_n)
        hazard_flush |=> (mem_wb == '0))
        else begin
            $error("mem_wb not cleared after flush");
            fail_count++;
        end

endmodule

/* sim/tb_mem_wb_backend.sv */
`timescale 1ns/1ps

module tb_mem_wb_backend
    import backend_pkg::*;
();

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 2;
    localparam int sweep_cycles    = 32;
    localparam int random_cycles   = 400;
    localparam int directed_cycles = 16;
    localparam int total_cycles    = reset_cycles + sweep_cycles + 3 * random_cycles
                                     + directed_cycles;
    localparam int watchdog_ns     = total_cycles * clk_period + 2000;

    logic                  clk;
    logic                  reset_n;
    ex_mem_t               ex_mem;
    logic                  hazard_stall;
    logic                  hazard_flush;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    mem_wb_t               mem_wb;
    reg_write_t            reg_write;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;

    // reference model state
    logic [xlen-1:0] model_mem [mem_depth];
    logic [xlen-1:0] model_regs [32];
    mem_wb_t         model_wb;

    integer seed = 32'h913b_75fe;
    int     error_count;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    int     assert_fails;

    mem_wb_backend UUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .hazard_stall (hazard_stall),
        .hazard_flush (hazard_flush),
        .ex_mem       (ex_mem),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .mem_wb       (mem_wb),
        .reg_write    (reg_write),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    bind mem_stage mem_wb_assertions u_mem_wb_assertions (
        .clk          (clk),
        .reset_n      (reset_n),
        .hazard_stall (hazard_stall),
        .hazard_flush (hazard_flush),
        .ex_mem       (ex_mem),
        .mem_we       (mem_we),
        .mem_wb       (mem_wb)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("sim failed");
        $finish;
    end

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic compare_mem_wb(input mem_wb_t got, input mem_wb_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic compare_reg_write(input reg_write_t got, input reg_write_t exp,
                                     input string what);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic compare_word(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
            count_error();
        end
    endtask

    // write request formed from the pending writeback bundle
    function automatic reg_write_t expected_write(input mem_wb_t wb);
        reg_write_t wr;
        wr.en   = wb.valid && wb.reg_write && (wb.rd != 5'd0);
        wr.rd   = wb.rd;
        wr.data = wb.mem_to_reg ? wb.read_data : wb.alu_result;
        return wr;
    endfunction

    function automatic logic [xlen-1:0] model_read(input logic [reg_addr_w-1:0] addr,
                                                   input reg_write_t wr);
        logic [xlen-1:0] value;
        if (wr.en && wr.rd == addr) begin
            value = wr.data;            // write-first bypass
        end else if (addr == 5'd0) begin
            value = '0;
        end else begin
            value = model_regs[addr];
        end
        return value;
    endfunction

    // what the next rising edge does to memory, registers and mem_wb
    task automatic advance_model(input ex_mem_t b, input logic stall, input logic flush,
                                 input reg_write_t wr);
        logic [mem_index_w-1:0] idx;
        logic [1:0]             lane;
        logic [7:0]             byte_val;
        logic [xlen-1:0]        word;
        logic [xlen-1:0]        load_val;
        logic                   take;
        idx      = b.alu_result[11:2];
        lane     = b.alu_result[1:0];
        word     = model_mem[idx];  // contents before the edge
        byte_val = word[lane*8 +: 8];
        take     = b.valid && !stall && !flush;
        case (b.mem_op)
            mem_lw:  load_val = word;
            mem_lb:  load_val = {{(xlen-8){byte_val[7]}}, byte_val};
            mem_lbu: load_val = {{(xlen-8){1'b0}}, byte_val};
            default: load_val = '0;
        endcase
        if (wr.en) begin
            model_regs[wr.rd] = wr.data;
        end
        if (take && b.mem_op == mem_sw) begin
            model_mem[idx] = b.write_data;
        end
        if (take && b.mem_op == mem_sb) begin
            model_mem[idx][lane*8 +: 8] = b.write_data[7:0];
        end
        if (flush) begin
            model_wb = '0;
        end else if (stall || !b.valid) begin
            model_wb.valid = 1'b0;  // contents stay
        end else begin
            model_wb.valid      = 1'b1;
            model_wb.pc         = b.pc;
            model_wb.read_data  = load_val;
            model_wb.alu_result = b.alu_result;
            model_wb.rd         = b.rd;
            model_wb.reg_write  = b.reg_write;
            model_wb.mem_to_reg = b.mem_to_reg;
        end
    endtask

    // one cycle: drive on the falling edge, check settled outputs, step the model
    task automatic apply(input ex_mem_t b, input logic stall, input logic flush,
                         input logic [reg_addr_w-1:0] a1, input logic [reg_addr_w-1:0] a2);
        reg_write_t exp_wr;
        @(negedge clk);
        ex_mem       = b;
        hazard_stall = stall;
        hazard_flush = flush;
        rs1_addr     = a1;
        rs2_addr     = a2;
        #1;
        exp_wr = expected_write(model_wb);
        compare_mem_wb(mem_wb, model_wb, "mem_wb");
        compare_reg_write(reg_write, exp_wr, "reg_write");
        compare_word(rs1_data, model_read(a1, exp_wr), "rs1_data");
        compare_word(rs2_data, model_read(a2, exp_wr), "rs2_data");
        advance_model(b, stall, flush, exp_wr);
    endtask

    task automatic make_bundle(output ex_mem_t b);
        logic [31:0] r;
        r            = $random(seed);
        b            = '0;
        b.valid      = (r[2:0] != 3'd0);
        b.mem_op     = mem_op_e'(r[5:3] % 3'd6);
        b.rd         = r[10:6];
        b.pc         = $random(seed) & 32'hffff_fffc;
        b.write_data = $random(seed);
        // 64-word window, upper bits random so the index wraps
        b.alu_result = ($random(seed) & 32'hffff_f000) | {24'd0, r[20:13]};
        case (b.mem_op)
            mem_lw, mem_lb, mem_lbu: begin
                b.reg_write  = 1'b1;
                b.mem_to_reg = 1'b1;
            end
            mem_sw, mem_sb: begin
                b.reg_write  = 1'b0;
                b.mem_to_reg = 1'b0;
            end
            default: begin
                b.alu_result = $random(seed);
                b.reg_write  = r[11] | r[12];
                b.mem_to_reg = r[21] & r[22];
            end
        endcase
        if (b.mem_op == mem_lw || b.mem_op == mem_sw) begin
            b.alu_result[1:0] = 2'b00;
        end
    endtask

    task automatic run_random(input int cycles, input int stall_pct, input int flush_pct);
        ex_mem_t               b;
        logic [31:0]           r;
        logic                  stall;
        logic                  flush;
        logic [reg_addr_w-1:0] a1;
        for (int i = 0; i < cycles; i++) begin
            make_bundle(b);
            r     = $random(seed);
            stall = (int'(r[7:0]) % 100) < stall_pct;
            flush = (int'(r[15:8]) % 100) < flush_pct;
            a1    = r[16] ? model_wb.rd : r[12:8];  // often hit the pending write
            apply(b, stall, flush, a1, r[21:17]);
        end
    endtask

    task automatic stall_directed();
        ex_mem_t         b;
        logic [xlen-1:0] old_word;
        b            = '0;
        b.valid      = 1'b1;
        b.pc         = 32'h0000_0100;
        b.mem_op     = mem_sw;
        b.alu_result = 32'h0000_0040;
        b.write_data = 32'hcafe_0001;
        old_word     = b.write_data;
        apply(b, 1'b0, 1'b0, 5'd0, 5'd0);
        b.write_data = 32'h5a5a_a5a5;
        apply(b, 1'b1, 1'b0, 5'd0, 5'd0);   // store under stall
        b.mem_op     = mem_lw;
        b.rd         = 5'd7;
        b.reg_write  = 1'b1;
        b.mem_to_reg = 1'b1;
        apply(b, 1'b0, 1'b0, 5'd0, 5'd0);
        b = '0;
        apply(b, 1'b0, 1'b0, 5'd7, 5'd0);
        compare_word(mem_wb.read_data, old_word, "load after stalled store");
        compare_word(rs1_data, old_word, "bypass of loaded word");
    endtask

    task automatic flush_directed();
        ex_mem_t         b;
        ex_mem_t         idle;
        logic [xlen-1:0] prior_r9;
        idle         = '0;
        b            = '0;
        b.valid      = 1'b1;
        b.mem_op     = mem_sw;
        b.alu_result = 32'h0000_0044;
        b.write_data = 32'h0bad_f00d;
        apply(b, 1'b0, 1'b0, 5'd0, 5'd0);
        b.write_data = 32'hdead_beef;
        apply(b, 1'b1, 1'b1, 5'd0, 5'd0);   // flush wins over stall
        prior_r9     = model_regs[9];
        b            = '0;
        b.valid      = 1'b1;
        b.rd         = 5'd9;
        b.reg_write  = 1'b1;
        b.alu_result = 32'h0000_1234;
        apply(b, 1'b0, 1'b1, 5'd9, 5'd0);
        apply(idle, 1'b0, 1'b0, 5'd9, 5'd0);
        compare_mem_wb(mem_wb, '0, "mem_wb after flush");
        apply(idle, 1'b0, 1'b0, 5'd9, 5'd0);
        compare_word(rs1_data, prior_r9, "r9 after flushed write");
        b            = '0;
        b.valid      = 1'b1;
        b.mem_op     = mem_lw;
        b.alu_result = 32'h0000_0044;
        b.mem_to_reg = 1'b1;
        apply(b, 1'b0, 1'b0, 5'd0, 5'd0);
        apply(idle, 1'b0, 1'b0, 5'd0, 5'd0);
        compare_word(mem_wb.read_data, 32'h0bad_f00d, "load after flushed store");
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        ex_mem_t idle;
        idle         = '0;
        reset_n      = 1'b0;
        ex_mem       = '0;
        hazard_stall = 1'b0;
        hazard_flush = 1'b0;
        rs1_addr     = '0;
        rs2_addr     = '0;
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_wb     = '0;
        for (int i = 0; i < mem_depth; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // every register reads zero on both ports
        for (int i = 0; i < sweep_cycles; i++) begin
            apply(idle, 1'b0, 1'b0, 5'(i), 5'(31 - i));
            compare_word(rs1_data, '0, "rs1_data after reset");
            compare_word(rs2_data, '0, "rs2_data after reset");
            if (mem_wb.valid !== 1'b0 || reg_write.en !== 1'b0) begin
                $display("error at %0t: strobe high after reset", $time);
                count_error();
            end
        end
        finish_test("reset");

        run_random(random_cycles, 0, 0);
        finish_test("random stream");

        run_random(random_cycles, 25, 0);
        stall_directed();
        finish_test("stall");

        flush_directed();
        run_random(random_cycles, 20, 15);
        apply(idle, 1'b0, 1'b0, 5'd0, 5'd0);
        finish_test("flush");

        assert_fails = UUT.u_mem_stage.u_mem_wb_assertions.fail_count;
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* flist.f */
hdl/backend_pkg.sv
hdl/data_memory.sv
hdl/mem_stage.sv
hdl/writeback_regfile.sv
hdl/mem_wb_backend.sv
sim/mem_wb_assertions.sv
sim/tb_mem_wb_backend.sv

/* Makefile */
VERILATOR  := verilator
FLIST      := flist.f
TB_TOP     := tb_mem_wb_backend
RTL_TOP    := mem_wb_backend
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_FLAGS  := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := sim failed
PASS_MSG   := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	-./$(OBJ_DIR)/V$(TB_TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "result: FAIL, run did not complete"; exit 1; fi
	@echo "result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
